// ==== verilog/plusTooMem_settings.svh ====
// build-wide sizes; PT_RESET_HOLD must be at least 1 and windows hold 2^PT_WINDOW_BITS words each
`ifndef PLUS_TOO_MEM_SETTINGS_SVH
`define PLUS_TOO_MEM_SETTINGS_SVH

// ----------------------------------------------------------------------------
// memory geometry
// ----------------------------------------------------------------------------

// log2 of words per window, the store holds four windows
`define PT_WINDOW_BITS 10

// window numbers in the top two store address bits
`define PT_REGION_RAM  2'd0
`define PT_REGION_ROM  2'd1 // system rom image
`define PT_REGION_DISK 2'd2 // floppy image, read byte wide

// ----------------------------------------------------------------------------
// cpu reset
// ----------------------------------------------------------------------------

// cycles cpuResetN stays low after a download or after rstN
`define PT_RESET_HOLD 16

`endif

// ==== verilog/downloadPkg.sv ====
// types of the byte stream from the io controller; one image per download, no framing here
`default_nettype none

package downloadPkg;

	// which image the io controller is sending
	typedef enum logic {
		imgRom  = 1'b0, // system rom
		imgDisk = 1'b1  // floppy disk image
	} imageIndex_e;

	// one streamed byte, tagged with its image
	typedef struct packed {
		imageIndex_e index; // must match the index given at dlStart
		logic [7:0]  data;
	} dlByte_t;

endpackage

`default_nettype wire

// ==== verilog/memMapPkg.sv ====
// memory map types; strobes uds and lds are active high here, not the bus's active-low pins
`default_nettype none
`include "plusTooMem_settings.svh"

package memMapPkg;

	// ------------------------------------------------------------------------
	// data word
	// ------------------------------------------------------------------------

	typedef struct packed {
		logic [7:0] hi; // even byte address
		logic [7:0] lo; // odd byte address
	} bytePair_t;

	// whole word for ram/rom, byte pair for disk image reads
	typedef union packed {
		logic [15:0] word;
		bytePair_t   bytes;
	} memWord_u;

	// ------------------------------------------------------------------------
	// bus and store ports
	// ------------------------------------------------------------------------

	// store window, lives in the top two address bits
	typedef enum logic [1:0] {
		regionRam  = `PT_REGION_RAM,
		regionRom  = `PT_REGION_ROM,
		regionDisk = `PT_REGION_DISK
	} region_e;

	// one cpu bus cycle
	typedef struct packed {
		logic [21:0] addr;     // byte address
		logic        uds;      // upper byte lane
		logic        lds;      // lower byte lane
		logic        write;
		logic        romSel;   // rom window
		logic        extraRom; // disk image, byte wide
		logic [15:0] wdata;
	} memReq_t;

	// one write into the word store
	typedef struct packed {
		logic [`PT_WINDOW_BITS+1:0] addr;   // window number on top
		logic [1:0]                 laneEn; // [1] hi byte, [0] lo byte
		memWord_u                   data;
	} storeWrite_t;

endpackage

`default_nettype wire

// ==== verilog/wordStore.sv ====
// on-chip word store, no reset; a read of a word written in the same cycle returns the old word
`timescale 1ns/1ps
`default_nettype none
`include "plusTooMem_settings.svh"

module wordStore (
	input  wire                             clk8,
	input  wire                             wr,
	input  wire memMapPkg::storeWrite_t     wrPort,
	input  wire                             rd,
	input  wire [`PT_WINDOW_BITS+1:0]       rdAddr,
	output memMapPkg::memWord_u             rdWord // valid the cycle after rd
);
	import memMapPkg::*;

	localparam int depth = 4 << `PT_WINDOW_BITS; // ram, rom, disk and one spare

	memWord_u mem [depth];

	// ------------------------------------------------------------------------
	// write port, per lane
	// ------------------------------------------------------------------------

	always_ff @(posedge clk8) begin
		if (wr) begin
			if (wrPort.laneEn[1])
				mem[wrPort.addr].bytes.hi <= wrPort.data.bytes.hi;
			if (wrPort.laneEn[0])
				mem[wrPort.addr].bytes.lo <= wrPort.data.bytes.lo;
		end
	end

	// ------------------------------------------------------------------------
	// read port
	// ------------------------------------------------------------------------

	// holds the last word between reads
	always_ff @(posedge clk8) begin
		if (rd)
			rdWord <= mem[rdAddr];
	end

endmodule

`default_nettype wire

// ==== verilog/downloadAssembler.sv ====
// pairs bytes high first into words; an odd last byte is dropped and the word address wraps
`timescale 1ns/1ps
`default_nettype none
`include "plusTooMem_settings.svh"

module downloadAssembler (
	input  wire                           clk8,
	input  wire                           rstN,
	input  wire                           dlStart,     // one cycle, opens a download
	input  wire downloadPkg::imageIndex_e dlIndex,
	input  wire                           dlByteValid, // one cycle per byte
	input  wire downloadPkg::dlByte_t     dlByte,
	input  wire                           dlEnd,       // one cycle, closes it
	output logic                          downloading,
	output logic                          dlWrite,     // one cycle per word
	output memMapPkg::storeWrite_t        dlWord,
	output downloadPkg::imageIndex_e      dlImage
);
	import downloadPkg::*;

	logic [7:0]                 hiByte;  // first byte of the pair
	logic                       phase;   // set while hiByte is held
	logic [`PT_WINDOW_BITS-1:0] wordCnt; // window-local word address

	wire byteTake = dlByteValid && downloading;

	// ------------------------------------------------------------------------
	// control state
	// ------------------------------------------------------------------------

	always_ff @(posedge clk8 or negedge rstN) begin
		if (!rstN) begin
			downloading <= 1'b0;
			dlWrite     <= 1'b0;
			phase       <= 1'b0;
			wordCnt     <= '0;
			dlImage     <= imgRom;
		end else begin
			dlWrite <= 1'b0; // strobe
			if (dlStart) begin
				downloading <= 1'b1;
				phase       <= 1'b0;
				wordCnt     <= '0; // each image starts at word 0
				dlImage     <= dlIndex;
			end else if (byteTake) begin
				phase <= ~phase;
				if (phase) begin // second byte completes the word
					dlWrite <= 1'b1;
					wordCnt <= wordCnt + 1'b1; // wraps in window
				end
			end
			if (dlEnd)
				downloading <= 1'b0; // end wins over a same-cycle start
		end
	end

	// ------------------------------------------------------------------------
	// word payload
	// ------------------------------------------------------------------------

	always_ff @(posedge clk8) begin
		if (byteTake && !phase)
			hiByte <= dlByte.data; // even address byte
		if (byteTake && phase) begin
			dlWord.addr      <= {2'b00, wordCnt}; // window added by the mux
			dlWord.laneEn    <= 2'b11;
			dlWord.data.word <= {hiByte, dlByte.data};
		end
	end

	// stream protocol from the io controller
	byteInsideDownload: assert property (@(posedge clk8) disable iff (!rstN)
		dlByteValid |-> downloading);
	byteMatchesImage: assert property (@(posedge clk8) disable iff (!rstN)
		dlByteValid && downloading |-> dlByte.index == dlImage);

endmodule

`default_nettype wire

// ==== verilog/memPortMux.sv ====
// cpu writes reach ram only; bytes above the window alias, and cpu writes are lost during downloads
`timescale 1ns/1ps
`default_nettype none
`include "plusTooMem_settings.svh"

module memPortMux (
	input  wire                           clk8,
	input  wire                           rstN,
	input  wire                           downloading,
	input  wire                           dlWrite,
	input  wire memMapPkg::storeWrite_t   dlWord,
	input  wire downloadPkg::imageIndex_e dlImage,
	input  wire                           cpuReq, // one cycle per bus access
	input  wire memMapPkg::memReq_t       req,
	output logic                          cpuResetN,
	output logic                          readPending, // store word valid now
	output logic                          forceOnes,
	output logic                          byteMode,
	output logic                          byteSel,     // 1 picks the lo byte
	output memMapPkg::memWord_u           storeData
);
	import downloadPkg::*;
	import memMapPkg::*;

	localparam int holdBits = $clog2(`PT_RESET_HOLD + 1);

	region_e                    dlRegion;
	region_e                    cpuRegion;
	logic [`PT_WINDOW_BITS+1:0] cpuAddr;  // full store word address
	storeWrite_t                storeWr;
	logic                       cpuWrite;
	logic                       cpuRead;
	logic [holdBits-1:0]        holdCnt;

	// ------------------------------------------------------------------------
	// address map
	// ------------------------------------------------------------------------

	assign dlRegion = (dlImage == imgRom) ? regionRom : regionDisk;

	always_comb begin
		cpuRegion = regionRam; // everything else is ram
		if (req.extraRom)
			cpuRegion = regionDisk;
		else if (req.romSel)
			cpuRegion = regionRom;
		cpuAddr = {cpuRegion, req.addr[`PT_WINDOW_BITS:1]}; // upper bits dropped, alias
	end

	// rom and disk windows are read only for the cpu
	assign cpuWrite = cpuReq && req.write && !downloading && !req.romSel && !req.extraRom
		&& (req.uds || req.lds);
	assign cpuRead  = cpuReq && !req.write;

	// download side owns the write port while it writes
	always_comb begin
		if (dlWrite) begin
			storeWr.addr   = {dlRegion, dlWord.addr[`PT_WINDOW_BITS-1:0]};
			storeWr.laneEn = dlWord.laneEn;
			storeWr.data   = dlWord.data;
		end else begin
			storeWr.addr      = cpuAddr;
			storeWr.laneEn    = {req.uds, req.lds};
			storeWr.data.word = req.wdata;
		end
	end

	wordStore store0 (
		.clk8   (clk8),
		.wr     (dlWrite || cpuWrite),
		.wrPort (storeWr),
		.rd     (cpuRead),
		.rdAddr (cpuAddr),
		.rdWord (storeData)
	);

	// ------------------------------------------------------------------------
	// read tags, lined up with the store output
	// ------------------------------------------------------------------------

	always_ff @(posedge clk8 or negedge rstN) begin
		if (!rstN)
			readPending <= 1'b0;
		else
			readPending <= cpuRead;
	end

	always_ff @(posedge clk8) begin
		forceOnes <= downloading; // screen stays black while loading
		byteMode  <= req.extraRom;
		byteSel   <= req.addr[0];
	end

	// ------------------------------------------------------------------------
	// cpu reset stretch
	// ------------------------------------------------------------------------

	// reload one short, the cycle that drops downloading counts as the first
	always_ff @(posedge clk8 or negedge rstN) begin
		if (!rstN)
			holdCnt <= holdBits'(`PT_RESET_HOLD);
		else if (downloading)
			holdCnt <= holdBits'(`PT_RESET_HOLD - 1);
		else if (holdCnt != '0)
			holdCnt <= holdCnt - 1'b1;
	end

	assign cpuResetN = !downloading && (holdCnt == '0);

	// assembler strobe may trail downloading by a cycle
	singleWriter: assert property (@(posedge clk8) disable iff (!rstN)
		!(dlWrite && cpuWrite));

endmodule

`default_nettype wire

// ==== verilog/readReturn.sv ====
// shapes one store word per readPending; rdData holds its last value while rdValid is low
`timescale 1ns/1ps
`default_nettype none

module readReturn (
	input  wire                       clk8,
	input  wire                       rstN,
	input  wire                       readPending,
	input  wire                       forceOnes, // download in progress
	input  wire                       byteMode,  // disk image read
	input  wire                       byteSel,   // 1 takes the lo byte
	input  wire memMapPkg::memWord_u  storeData,
	output logic                      rdValid,
	output memMapPkg::memWord_u       rdData
);
	import memMapPkg::*;

	memWord_u shaped;

	// byte reads put the byte on both lanes, cpu uses either strobe
	always_comb begin
		shaped = storeData;
		if (forceOnes)
			shaped.word = 16'hFFFF;
		else if (byteMode) begin
			if (byteSel)
				shaped.bytes.hi = storeData.bytes.lo; // odd byte
			else
				shaped.bytes.lo = storeData.bytes.hi; // even byte
		end
	end

	// ------------------------------------------------------------------------
	// output register
	// ------------------------------------------------------------------------

	always_ff @(posedge clk8 or negedge rstN) begin
		if (!rstN)
			rdValid <= 1'b0;
		else
			rdValid <= readPending;
	end

	always_ff @(posedge clk8) begin
		if (readPending)
			rdData <= shaped;
	end

endmodule

`default_nettype wire

// ==== verilog/plusTooMem.sv ====
// memory side of the replica; one clock domain, no back-pressure, reads return two cycles later
`timescale 1ns/1ps
`default_nettype none

module plusTooMem (
	input  wire                           clk8,
	input  wire                           rstN,
	input  wire                           dlStart,
	input  wire downloadPkg::imageIndex_e dlIndex,
	input  wire                           dlByteValid,
	input  wire downloadPkg::dlByte_t     dlByte,
	input  wire                           dlEnd,
	input  wire                           cpuReq,
	input  wire memMapPkg::memReq_t       req,
	output wire                           downloading,
	output wire                           cpuResetN,
	output wire                           rdValid,
	output wire memMapPkg::memWord_u      rdData
);
	import downloadPkg::*;
	import memMapPkg::*;

	// assembler to mux
	wire              dlWrite;
	wire storeWrite_t dlWord;
	wire imageIndex_e dlImage;

	// mux to read return
	wire              readPending;
	wire              forceOnes;
	wire              byteMode;
	wire              byteSel;
	wire memWord_u    storeData;

	downloadAssembler asm0 (
		.clk8        (clk8),
		.rstN        (rstN),
		.dlStart     (dlStart),
		.dlIndex     (dlIndex),
		.dlByteValid (dlByteValid),
		.dlByte      (dlByte),
		.dlEnd       (dlEnd),
		.downloading (downloading),
		.dlWrite     (dlWrite),
		.dlWord      (dlWord),
		.dlImage     (dlImage)
	);

	memPortMux mux0 (
		.clk8        (clk8),
		.rstN        (rstN),
		.downloading (downloading),
		.dlWrite     (dlWrite),
		.dlWord      (dlWord),
		.dlImage     (dlImage),
		.cpuReq      (cpuReq),
		.req         (req),
		.cpuResetN   (cpuResetN),
		.readPending (readPending),
		.forceOnes   (forceOnes),
		.byteMode    (byteMode),
		.byteSel     (byteSel),
		.storeData   (storeData)
	);

	readReturn ret0 (
		.clk8        (clk8),
		.rstN        (rstN),
		.readPending (readPending),
		.forceOnes   (forceOnes),
		.byteMode    (byteMode),
		.byteSel     (byteSel),
		.storeData   (storeData),
		.rdValid     (rdValid),
		.rdData      (rdData)
	);

endmodule

`default_nettype wire

// ==== tb/plusTooMemTb.sv ====
// assumes PT_WINDOW_BITS of at least 6 and PT_RESET_HOLD above 0; random data is fixed by seed 12
`timescale 1ns/1ps
`default_nettype none
`include "plusTooMem_settings.svh"

module plusTooMemTb;
	import downloadPkg::*;
	import memMapPkg::*;

	localparam int winWords   = 1 << `PT_WINDOW_BITS;
	localparam int romBytes   = 64;
	localparam int diskBytes  = 32;
	localparam int ramWords   = 12; // ram words touched by the write test
	localparam int cycleLimit = 16 * (romBytes + diskBytes + 6 * ramWords)
		+ 40 * `PT_RESET_HOLD + 500;

	typedef struct packed {
		logic        valid;
		logic [15:0] word;
	} expRead_t;

	logic          clk8 = 1'b0;
	logic          rstN;
	logic          dlStart;
	imageIndex_e   dlIndex;
	logic          dlByteValid;
	dlByte_t       dlByte;
	logic          dlEnd;
	logic          cpuReq;
	memReq_t       req;
	wire           downloading;
	wire           cpuResetN;
	wire           rdValid;
	wire memWord_u rdData;

	// reference model with one array per window
	logic [15:0] ramModel  [winWords];
	logic [15:0] romModel  [winWords];
	logic [7:0]  diskModel [2 * winWords]; // byte wide view
	expRead_t    expNext;     // goes with the read strobe
	expRead_t    expPipe [2]; // two expected reads in flight
	logic        dlActive;    // stimulus view of a download
	logic        inDl;        // edge view for downloading and cpuResetN
	int          cycle;
	int          lastEnd;     // cycle of dlEnd or of reset release
	int          seed;
	int          dataErrors;
	int          validErrors;
	int          resetErrors;
	int          dlErrors;

	wire        expValid  = expPipe[1].valid;
	wire [15:0] expWord   = expPipe[1].word;
	wire        expResetN = !inDl && (cycle >= lastEnd + `PT_RESET_HOLD);

	plusTooMem dut0 (
		.clk8        (clk8),
		.rstN        (rstN),
		.dlStart     (dlStart),
		.dlIndex     (dlIndex),
		.dlByteValid (dlByteValid),
		.dlByte      (dlByte),
		.dlEnd       (dlEnd),
		.cpuReq      (cpuReq),
		.req         (req),
		.downloading (downloading),
		.cpuResetN   (cpuResetN),
		.rdValid     (rdValid),
		.rdData      (rdData)
	);

	always #4 clk8 = ~clk8; // 8 ns

	// ------------------------------------------------------------------------
	// scoreboard timing and checks
	// ------------------------------------------------------------------------

	always @(posedge clk8) begin
		cycle      <= cycle + 1;
		expPipe[0] <= expNext; // strobe seen by the dut
		expPipe[1] <= expPipe[0];
		if (!rstN) begin
			inDl    <= 1'b0;
			lastEnd <= cycle + 1; // release seen on the next edge
		end else begin
			if (dlStart)
				inDl <= 1'b1;
			if (dlEnd) begin
				inDl    <= 1'b0;
				lastEnd <= cycle;
			end
		end
	end

	readValidCheck: assert property (@(posedge clk8) disable iff (!rstN)
		rdValid == expValid)
		else begin
			validErrors++;
			$display("FAIL rdValid got %h exp %h", $sampled(rdValid), $sampled(expValid));
		end

	readDataCheck: assert property (@(posedge clk8) disable iff (!rstN)
		rdValid |-> rdData == expWord)
		else begin
			dataErrors++;
			$display("FAIL rdData got %h exp %h", $sampled(rdData), $sampled(expWord));
		end

	resetHoldCheck: assert property (@(posedge clk8) disable iff (!rstN)
		cpuResetN == expResetN)
		else begin
			resetErrors++;
			$display("FAIL cpuResetN got %h exp %h", $sampled(cpuResetN), $sampled(expResetN));
		end

	// high from the edge that takes dlStart to the edge that takes dlEnd
	downloadingCheck: assert property (@(posedge clk8) disable iff (!rstN)
		downloading == inDl)
		else begin
			dlErrors++;
			$display("FAIL downloading got %h exp %h", $sampled(downloading), $sampled(inDl));
		end

	always @(posedge clk8) begin
		if (cycle >= cycleLimit) begin
			$display("timeout, stimulus still running after %0d cycles", cycle);
			$display("errors: rdData %0d, rdValid %0d, cpuResetN %0d, downloading %0d",
				dataErrors, validErrors, resetErrors, dlErrors);
			$display("Test failures found");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// stimulus tasks
	// ------------------------------------------------------------------------

	// one edge with all strobes back to idle
	task automatic nextCycle();
		@(posedge clk8);
		dlStart     <= 1'b0;
		dlByteValid <= 1'b0;
		dlEnd       <= 1'b0;
		cpuReq      <= 1'b0;
		expNext     <= '0;
	endtask

	function automatic logic [15:0] ramWord(input logic [21:0] addr);
		return ramModel[addr[`PT_WINDOW_BITS:1]]; // upper bits alias
	endfunction

	task automatic readAt(input logic [21:0] addr, input logic romSel, input logic extraRom,
			input logic [15:0] want);
		memReq_t r;
		nextCycle();
		r          = '0;
		r.addr     = addr;
		r.romSel   = romSel;
		r.extraRom = extraRom;
		cpuReq  <= 1'b1;
		req     <= r;
		expNext <= {1'b1, want};
	endtask

	task automatic writeAt(input logic [21:0] addr, input logic [1:0] lanes,
			input logic romSel, input logic extraRom, input logic [15:0] wdata);
		memReq_t                    r;
		logic [`PT_WINDOW_BITS-1:0] idx;
		nextCycle();
		r          = '0;
		r.addr     = addr;
		r.uds      = lanes[1];
		r.lds      = lanes[0];
		r.write    = 1'b1;
		r.romSel   = romSel;
		r.extraRom = extraRom;
		r.wdata    = wdata;
		cpuReq <= 1'b1;
		req    <= r;
		idx = addr[`PT_WINDOW_BITS:1];
		if (!dlActive && !romSel && !extraRom) begin // only ram takes cpu writes
			if (lanes[1])
				ramModel[idx][15:8] = wdata[15:8];
			if (lanes[0])
				ramModel[idx][7:0] = wdata[7:0];
		end
	endtask

	// streams one image with cpu traffic in some of the gaps
	task automatic sendImage(input imageIndex_e idx, input int nBytes);
		logic [7:0] b;
		nextCycle();
		dlStart <= 1'b1;
		dlIndex <= idx;
		dlActive = 1'b1;
		nextCycle();
		for (int i = 0; i < nBytes; i++) begin
			b = 8'($random(seed));
			if (idx == imgDisk)
				diskModel[i] = b;
			else if (i[0])
				romModel[i / 2][7:0] = b; // second byte is low
			else
				romModel[i / 2][15:8] = b;
			nextCycle();
			dlByteValid <= 1'b1;
			dlByte      <= {idx, b};
			if (i == 9)
				readAt(22'h000000, 1'b0, 1'b0, 16'hFFFF); // screen dark while loading
			else if (i == 17)
				writeAt(22'h000000, 2'b11, 1'b0, 1'b0, ~ramModel[0]); // must be dropped
			else if (i == 25)
				readAt(22'h000002, 1'b1, 1'b0, 16'hFFFF);
			else
				nextCycle();
		end
		nextCycle();
		dlEnd <= 1'b1;
		dlActive = 1'b0;
		nextCycle();
		while (!cpuResetN)
			@(posedge clk8); // cpu held until the hold time runs out
	endtask

	// ------------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------------

	initial begin
		logic [21:0] a;
		int          w;
		seed        = 12;
		dataErrors  = 0;
		validErrors = 0;
		resetErrors = 0;
		dlErrors    = 0;
		cycle       = 0;
		lastEnd     = 0;
		inDl        = 1'b0;
		dlActive    = 1'b0;
		expNext     = '0;
		expPipe[0]  = '0;
		expPipe[1]  = '0;
		rstN        = 1'b0;
		dlStart     = 1'b0;
		dlIndex     = imgRom;
		dlByteValid = 1'b0;
		dlByte      = '0;
		dlEnd       = 1'b0;
		cpuReq      = 1'b0;
		req         = '0;
		repeat (2) @(posedge clk8);
		rstN <= 1'b1;

		// ram gets a full word and then random lanes, read back through an alias
		for (int k = 0; k < ramWords; k++) begin
			w = (k * 71) % winWords;
			a = 22'(w * 2);
			writeAt(a, 2'b11, 1'b0, 1'b0, 16'($random(seed)));
			writeAt(a, 2'($random(seed)), 1'b0, 1'b0, 16'($random(seed)));
			readAt(a + 22'(2 * winWords * (1 + k % 3)), 1'b0, 1'b0, ramWord(a));
		end

		sendImage(imgRom, romBytes);
		for (int i = 0; i < romBytes / 2; i++)
			readAt(22'(2 * i), 1'b1, 1'b0, romModel[i]);
		readAt(22'h000000, 1'b0, 1'b0, ramWord(22'h000000)); // untouched by the download

		sendImage(imgDisk, diskBytes);
		for (int n = 0; n < diskBytes; n++)
			readAt(22'(n), 1'b0, 1'b1, {diskModel[n], diskModel[n]});

		// cpu writes into read-only windows and then reads back to back
		writeAt(22'h000002, 2'b11, 1'b1, 1'b0, 16'h1234);
		writeAt(22'h000004, 2'b11, 1'b0, 1'b1, 16'h5678);
		readAt(22'h000002, 1'b1, 1'b0, romModel[1]);
		readAt(22'h000004, 1'b0, 1'b1, {diskModel[4], diskModel[4]});
		readAt(22'h000005, 1'b0, 1'b1, {diskModel[5], diskModel[5]});
		repeat (4) nextCycle(); // drain

		$display("errors: rdData %0d, rdValid %0d, cpuResetN %0d, downloading %0d",
			dataErrors, validErrors, resetErrors, dlErrors);
		if (dataErrors + validErrors + resetErrors + dlErrors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+verilog
verilog/downloadPkg.sv
verilog/memMapPkg.sv
verilog/wordStore.sv
verilog/downloadAssembler.sv
verilog/memPortMux.sv
verilog/readReturn.sv
verilog/plusTooMem.sv
tb/plusTooMemTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory side testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f tb.f --top-module plusTooMemTb -o plusTooMemSim

out=$(./obj_dir/plusTooMemSim)
echo "$out"

# pass only if the testbench printed its pass line
echo "$out" | grep -qx "All tests passed!"
